/* bench/gbe_clock_gen.sv */
`timescale 1ns/1ns

module gbe_clock_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

endmodule

/* bench/gbe_props.sv */
`timescale 1ns/1ns

module gbe_props (
    input logic       user_clk,
    input logic       rst,
    input logic       gbe_rst,
    input logic [3:0] gbe_rx_valid,
    input logic       gbe_rx_bad_frame,
    input logic       gbe_tx_overflow
);

    // Count of failed assertions
    int assert_fails = 0;

    // All four valid bits come from one empty flag
    rx_valid_uniform: assert property (@(posedge user_clk) disable iff (rst)
        (gbe_rx_valid == 4'h0) || (gbe_rx_valid == 4'hF))
        else begin
            assert_fails++;
            $error("gbe_rx_valid bits disagree");
        end

    bad_frame_single: assert property (@(posedge user_clk) disable iff (rst)
        gbe_rx_bad_frame |=> !gbe_rx_bad_frame)
        else begin
            assert_fails++;
            $error("gbe_rx_bad_frame held for two cycles");
        end

    // Sticky flag, only a reset may clear it
    overflow_sticky: assert property (@(posedge user_clk)
        $fell(gbe_tx_overflow) |-> $past(rst || gbe_rst))
        else begin
            assert_fails++;
            $error("gbe_tx_overflow fell without a reset");
        end

endmodule

bind casper_gbe_loopback gbe_props gbe_props_inst (
    .user_clk(user_clk),
    .rst(rst),
    .gbe_rst(gbe_rst),
    .gbe_rx_valid(gbe_rx_valid),
    .gbe_rx_bad_frame(gbe_rx_bad_frame),
    .gbe_tx_overflow(gbe_tx_overflow)
);

/* bench/gbe_tb.sv */
`timescale 1ns/1ns

module gbe_tb;

    import gbe_pkg::*;

    localparam ip_addr_t local_ip = 32'h0A000001;
    localparam udp_port_t src_port = 16'h1234;
    localparam int rx_depth = 16;
    localparam int tx_depth = 16;
    localparam int led_hold = 8;
    localparam int up_delay = 32;
    // About 40 frames of up to 8 words with ack gaps, well under this
    localparam int cycle_limit = 20000;

    typedef struct packed {
        logic      last;
        udp_port_t dport;
        ip_addr_t  dip;
        gbe_word_t data;
    } exp_word_t;

    logic clk;
    logic rst;
    logic gbe_rst;
    gbe_word_t gbe_tx_data;
    logic [3:0] gbe_tx_valid;
    logic gbe_tx_end_of_frame;
    ip_addr_t gbe_tx_dest_ip;
    udp_port_t gbe_tx_dest_port;
    logic gbe_rx_ack;
    logic gbe_rx_overrun_ack;
    logic gbe_tx_afull;
    logic gbe_tx_overflow;
    gbe_word_t gbe_rx_data;
    logic [3:0] gbe_rx_valid;
    ip_addr_t gbe_rx_source_ip;
    udp_port_t gbe_rx_source_port;
    ip_addr_t gbe_rx_dest_ip;
    udp_port_t gbe_rx_dest_port;
    logic gbe_rx_end_of_frame;
    logic gbe_rx_bad_frame;
    logic gbe_rx_overrun;
    logic gbe_led_up;
    logic gbe_led_rx;
    logic gbe_led_tx;

    logic [15:0] lfsr = 16'd60133;
    exp_word_t exp_q[$];
    int errors = 0;
    int checks = 0;
    int bad_count = 0;
    int cycles = 0;

    gbe_clock_gen #(.period(40)) clock_gen (.clk(clk));

    casper_gbe_loopback #(
        .local_ip(local_ip),
        .src_port(src_port),
        .tx_depth(tx_depth),
        .rx_depth(rx_depth),
        .led_hold(led_hold),
        .up_delay(up_delay)
    ) casper_gbe_loopback_inst (
        .user_clk(clk),
        .rst(rst),
        .gbe_rst(gbe_rst),
        .gbe_tx_data(gbe_tx_data),
        .gbe_tx_valid(gbe_tx_valid),
        .gbe_tx_end_of_frame(gbe_tx_end_of_frame),
        .gbe_tx_dest_ip(gbe_tx_dest_ip),
        .gbe_tx_dest_port(gbe_tx_dest_port),
        .gbe_rx_ack(gbe_rx_ack),
        .gbe_rx_overrun_ack(gbe_rx_overrun_ack),
        .gbe_tx_afull(gbe_tx_afull),
        .gbe_tx_overflow(gbe_tx_overflow),
        .gbe_rx_data(gbe_rx_data),
        .gbe_rx_valid(gbe_rx_valid),
        .gbe_rx_source_ip(gbe_rx_source_ip),
        .gbe_rx_source_port(gbe_rx_source_port),
        .gbe_rx_dest_ip(gbe_rx_dest_ip),
        .gbe_rx_dest_port(gbe_rx_dest_port),
        .gbe_rx_end_of_frame(gbe_rx_end_of_frame),
        .gbe_rx_bad_frame(gbe_rx_bad_frame),
        .gbe_rx_overrun(gbe_rx_overrun),
        .gbe_led_up(gbe_led_up),
        .gbe_led_rx(gbe_led_rx),
        .gbe_led_tx(gbe_led_tx)
    );

    // Taps 16, 14, 13, 11; one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check(input string name, input logic [511:0] expected,
                         input logic [511:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // Sampled away from the edge where the pulse changes
    always @(negedge clk) begin
        if (!rst && gbe_rx_bad_frame) begin
            bad_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic send_frame(input ip_addr_t ip, input udp_port_t port, input int len,
                              input bit expect_rx);
        exp_word_t w;
        logic [3:0] strobe;
        for (int i = 0; i < len; i++) begin
            for (int k = 0; k < 16; k++) begin
                w.data[k*32 +: 32] = take_bits(32);
            end
            w.last = (i == len - 1);
            w.dip = ip;
            w.dport = port;
            strobe = 4'(take_bits(4));
            if (strobe == 4'h0) begin
                strobe = 4'h1;
            end
            gbe_tx_data = w.data;
            gbe_tx_valid = strobe;
            gbe_tx_end_of_frame = w.last;
            gbe_tx_dest_ip = ip;
            gbe_tx_dest_port = port;
            if (expect_rx) begin
                exp_q.push_back(w);
            end
            tick();
        end
        gbe_tx_valid = 4'h0;
        gbe_tx_end_of_frame = 1'b0;
    endtask

    // Pops every expected word, with random gaps before each ack
    task automatic receive_all(input string name);
        exp_word_t w;
        int waited;
        int gap;
        while (exp_q.size() > 0) begin
            waited = 0;
            while (!gbe_rx_valid[0] && waited < 200) begin
                tick();
                waited++;
            end
            if (!gbe_rx_valid[0]) begin
                errors++;
                $display("Error in %s: no received word within 200 cycles", name);
                exp_q.delete();
                return;
            end
            gap = int'(take_bits(2));
            repeat (gap) tick();
            w = exp_q.pop_front();
            check({name, " data"}, w.data, gbe_rx_data);
            check({name, " end of frame"}, 512'(w.last), 512'(gbe_rx_end_of_frame));
            check({name, " source ip"}, 512'(local_ip), 512'(gbe_rx_source_ip));
            check({name, " source port"}, 512'(src_port), 512'(gbe_rx_source_port));
            check({name, " dest ip"}, 512'(w.dip), 512'(gbe_rx_dest_ip));
            check({name, " dest port"}, 512'(w.dport), 512'(gbe_rx_dest_port));
            gbe_rx_ack = 1'b1;
            tick();
            gbe_rx_ack = 1'b0;
        end
    endtask

    initial begin
        int bad_start;
        int waited;
        ip_addr_t other_ip;
        bit seen_tx;
        bit seen_rx;
        rst = 1'b1;
        gbe_rst = 1'b0;
        gbe_tx_data = '0;
        gbe_tx_valid = 4'h0;
        gbe_tx_end_of_frame = 1'b0;
        gbe_tx_dest_ip = '0;
        gbe_tx_dest_port = '0;
        gbe_rx_ack = 1'b0;
        gbe_rx_overrun_ack = 1'b0;
        repeat (10) tick();
        rst = 1'b0;

        // Link-up delay
        check("led up after reset", 512'(1'b0), 512'(gbe_led_up));
        repeat (up_delay - 2) tick();
        check("led up before delay", 512'(1'b0), 512'(gbe_led_up));
        repeat (4) tick();
        check("led up", 512'(1'b1), 512'(gbe_led_up));

        // Activity LEDs follow one frame
        send_frame(local_ip, 16'(take_bits(16)), 4, 1'b1);
        seen_tx = 1'b0;
        seen_rx = 1'b0;
        for (int i = 0; i < led_hold + 8; i++) begin
            seen_tx = seen_tx | gbe_led_tx;
            seen_rx = seen_rx | gbe_led_rx;
            tick();
        end
        check("led tx on", 512'(1'b1), 512'(seen_tx));
        check("led rx on", 512'(1'b1), 512'(seen_rx));
        receive_all("led frame");
        repeat (led_hold + 2) tick();
        check("led tx off", 512'(1'b0), 512'(gbe_led_tx));
        check("led rx off", 512'(1'b0), 512'(gbe_led_rx));

        // Loopback and header fields
        bad_start = bad_count;
        for (int f = 0; f < 40; f++) begin
            send_frame(local_ip, 16'(take_bits(16)), int'(take_bits(3)) + 1, 1'b1);
            receive_all("loopback");
        end
        check("loopback bad frames", 512'(bad_start), 512'(bad_count));

        // Address filter
        bad_start = bad_count;
        for (int f = 0; f < 5; f++) begin
            other_ip = take_bits(32);
            if (other_ip == local_ip) begin
                other_ip = other_ip ^ 32'h1;
            end
            send_frame(other_ip, 16'(take_bits(16)), int'(take_bits(3)) + 1, 1'b0);
            waited = 0;
            while (bad_count == bad_start + f && waited < 100) begin
                tick();
                waited++;
            end
        end
        repeat (20) tick();
        check("filter bad frames", 512'(bad_start + 5), 512'(bad_count));
        check("filter no words", 512'(4'h0), 512'(gbe_rx_valid));

        // Overrun, third frame finds the rx FIFO full
        send_frame(local_ip, 16'h0101, 8, 1'b1);
        send_frame(local_ip, 16'h0202, 8, 1'b1);
        send_frame(local_ip, 16'h0303, 8, 1'b0);
        waited = 0;
        while (!gbe_rx_overrun && waited < 200) begin
            tick();
            waited++;
        end
        check("overrun set", 512'(1'b1), 512'(gbe_rx_overrun));
        repeat (10) tick();
        check("overrun held", 512'(1'b1), 512'(gbe_rx_overrun));
        receive_all("overrun drain");
        check("overrun drained", 512'(4'h0), 512'(gbe_rx_valid));
        check("overrun before ack", 512'(1'b1), 512'(gbe_rx_overrun));
        gbe_rx_overrun_ack = 1'b1;
        tick();
        gbe_rx_overrun_ack = 1'b0;
        check("overrun cleared", 512'(1'b0), 512'(gbe_rx_overrun));
        send_frame(local_ip, 16'(take_bits(16)), 5, 1'b1);
        receive_all("after overrun");

        // Transmit flags, one open frame longer than the tx FIFO
        for (int i = 0; i < tx_depth + 4; i++) begin
            if (i == 11) begin
                check("afull below level", 512'(1'b0), 512'(gbe_tx_afull));
            end
            if (i == 12) begin
                check("afull at level", 512'(1'b1), 512'(gbe_tx_afull));
            end
            gbe_tx_data = {16{take_bits(32)}};
            gbe_tx_valid = 4'hF;
            gbe_tx_end_of_frame = 1'b0;
            tick();
        end
        gbe_tx_valid = 4'h0;
        check("afull when full", 512'(1'b1), 512'(gbe_tx_afull));
        check("overflow set", 512'(1'b1), 512'(gbe_tx_overflow));
        gbe_rst = 1'b1;
        tick();
        gbe_rst = 1'b0;
        check("afull after gbe_rst", 512'(1'b0), 512'(gbe_tx_afull));
        check("overflow after gbe_rst", 512'(1'b0), 512'(gbe_tx_overflow));

        repeat (5) tick();
        $display("Checks: %0d  errors: %0d  assertion failures: %0d  cycles: %0d",
                 checks, errors, casper_gbe_loopback_inst.gbe_props_inst.assert_fails,
                 cycles);
        if (errors == 0 && casper_gbe_loopback_inst.gbe_props_inst.assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* hw/casper_gbe_loopback.sv */
`timescale 1ns/1ns

module casper_gbe_loopback #(
    parameter gbe_pkg::ip_addr_t  local_ip = 32'h0A000001,
    parameter gbe_pkg::udp_port_t src_port = 16'h1234,
    parameter int                 tx_depth = 16,
    parameter int                 rx_depth = 16,
    parameter int                 afull_margin = 4,
    parameter int                 led_hold = 8,
    parameter int                 up_delay = 32
) (
    input  logic               user_clk,
    input  logic               rst,
    input  logic               gbe_rst,
    input  gbe_pkg::gbe_word_t gbe_tx_data,
    input  logic [3:0]         gbe_tx_valid,
    input  logic               gbe_tx_end_of_frame,
    input  gbe_pkg::ip_addr_t  gbe_tx_dest_ip,
    input  gbe_pkg::udp_port_t gbe_tx_dest_port,
    input  logic               gbe_rx_ack,
    input  logic               gbe_rx_overrun_ack,
    output logic               gbe_tx_afull,
    output logic               gbe_tx_overflow,
    output gbe_pkg::gbe_word_t gbe_rx_data,
    output logic [3:0]         gbe_rx_valid,
    output gbe_pkg::ip_addr_t  gbe_rx_source_ip,
    output gbe_pkg::udp_port_t gbe_rx_source_port,
    output gbe_pkg::ip_addr_t  gbe_rx_dest_ip,
    output gbe_pkg::udp_port_t gbe_rx_dest_port,
    output logic               gbe_rx_end_of_frame,
    output logic               gbe_rx_bad_frame,
    output logic               gbe_rx_overrun,
    output logic               gbe_led_up,
    output logic               gbe_led_rx,
    output logic               gbe_led_tx
);

    import gbe_pkg::*;

    // Word plus last flag, and on receive the four header fields as well
    localparam int tx_w = $bits(gbe_word_t) + 1;
    localparam int rx_w = tx_w + 2 * $bits(ip_addr_t) + 2 * $bits(udp_port_t);

    logic dp_rst;
    logic tx_wr;
    logic tx_full;
    logic tx_rd;
    logic tx_last;
    logic [$clog2(tx_depth+1)-1:0] tx_count;
    logic [tx_w-1:0] tx_rd_data;
    gbe_word_t tx_word;
    gbe_word_t link_data;
    logic link_valid;
    logic link_last;
    logic tx_active;
    logic rx_active;
    gbe_word_t rx_word;
    logic rx_wr;
    logic rx_last;
    logic rx_full;
    logic rx_empty;
    ip_addr_t rx_src_ip;
    ip_addr_t rx_dst_ip;
    udp_port_t rx_src_port;
    udp_port_t rx_dst_port;
    logic [rx_w-1:0] rx_wr_data;
    logic [rx_w-1:0] rx_rd_data;

    // Soft reset clears the datapath but leaves link-up alone
    assign dp_rst = rst | gbe_rst;
    assign tx_wr = |gbe_tx_valid;
    assign {tx_last, tx_word} = tx_rd_data;

    gbe_stream_fifo #(
        .width(tx_w),
        .depth(tx_depth)
    ) tx_fifo (
        .user_clk(user_clk),
        .rst(dp_rst),
        .wr_en(tx_wr),
        .wr_data({gbe_tx_end_of_frame, gbe_tx_data}),
        .rd_en(tx_rd),
        .rd_data(tx_rd_data),
        .full(tx_full),
        .empty(),
        .count(tx_count)
    );

    udp_tx_framer #(
        .local_ip(local_ip),
        .src_port(src_port),
        .tx_depth(tx_depth),
        .afull_margin(afull_margin)
    ) framer (
        .user_clk(user_clk),
        .rst(dp_rst),
        .wr_en(tx_wr),
        .wr_last(gbe_tx_end_of_frame),
        .fifo_full(tx_full),
        .fifo_count(tx_count),
        .fifo_data(tx_word),
        .fifo_last(tx_last),
        .dest_ip(gbe_tx_dest_ip),
        .dest_port(gbe_tx_dest_port),
        .fifo_rd(tx_rd),
        .link_data(link_data),
        .link_valid(link_valid),
        .link_last(link_last),
        .tx_afull(gbe_tx_afull),
        .tx_overflow(gbe_tx_overflow),
        .tx_active(tx_active)
    );

    // Link stands in for MAC and PHY
    udp_rx_parser #(
        .local_ip(local_ip)
    ) parser (
        .user_clk(user_clk),
        .rst(dp_rst),
        .link_data(link_data),
        .link_valid(link_valid),
        .link_last(link_last),
        .fifo_full(rx_full),
        .overrun_ack(gbe_rx_overrun_ack),
        .fifo_wr(rx_wr),
        .fifo_data(rx_word),
        .fifo_last(rx_last),
        .src_ip_o(rx_src_ip),
        .src_port_o(rx_src_port),
        .dst_ip_o(rx_dst_ip),
        .dst_port_o(rx_dst_port),
        .bad_frame(gbe_rx_bad_frame),
        .overrun(gbe_rx_overrun),
        .rx_active(rx_active)
    );

    assign rx_wr_data = {rx_last, rx_dst_port, rx_dst_ip, rx_src_port, rx_src_ip, rx_word};

    gbe_stream_fifo #(
        .width(rx_w),
        .depth(rx_depth)
    ) rx_fifo (
        .user_clk(user_clk),
        .rst(dp_rst),
        .wr_en(rx_wr),
        .wr_data(rx_wr_data),
        .rd_en(gbe_rx_ack),
        .rd_data(rx_rd_data),
        .full(rx_full),
        .empty(rx_empty),
        .count()
    );

    assign {gbe_rx_end_of_frame, gbe_rx_dest_port, gbe_rx_dest_ip,
            gbe_rx_source_port, gbe_rx_source_ip, gbe_rx_data} = rx_rd_data;
    assign gbe_rx_valid = {4{!rx_empty}};

    gbe_activity_leds #(
        .led_hold(led_hold),
        .up_delay(up_delay)
    ) leds (
        .user_clk(user_clk),
        .rst(rst),
        .tx_active(tx_active),
        .rx_active(rx_active),
        .led_up(gbe_led_up),
        .led_rx(gbe_led_rx),
        .led_tx(gbe_led_tx)
    );

endmodule

/* hw/gbe_activity_leds.sv */
`timescale 1ns/1ns

module gbe_activity_leds #(
    parameter int led_hold = 8,
    parameter int up_delay = 32
) (
    input  logic user_clk,
    input  logic rst,
    input  logic tx_active,
    input  logic rx_active,
    output logic led_up,
    output logic led_rx,
    output logic led_tx
);

    localparam int hold_w = $clog2(led_hold + 1);
    localparam int up_w = $clog2(up_delay + 1);

    logic [up_w-1:0] up_cnt;
    logic [hold_w-1:0] hold_cnt [2];
    logic [1:0] activity;

    // Index 0 is tx, index 1 is rx
    assign activity = {rx_active, tx_active};

    always_ff @(posedge user_clk) begin
        if (rst) begin
            up_cnt <= up_w'(up_delay);
            led_up <= 1'b0;
        end else begin
            if (up_cnt != '0) begin
                up_cnt <= up_cnt - 1'b1;
            end
            led_up <= (up_cnt <= up_w'(1));
        end
    end

    // Reload on every active cycle, then count down to dark
    always_ff @(posedge user_clk) begin
        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                hold_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (activity[i]) begin
                    hold_cnt[i] <= hold_w'(led_hold);
                end else if (hold_cnt[i] != '0) begin
                    hold_cnt[i] <= hold_cnt[i] - 1'b1;
                end
            end
        end
    end

    assign led_tx = (hold_cnt[0] != '0);
    assign led_rx = (hold_cnt[1] != '0);

endmodule

/* hw/gbe_pkg.sv */
package gbe_pkg;

    // One streaming word, on the user side and on the link
    typedef logic [511:0] gbe_word_t;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    // Frame length in payload words, not bytes
    typedef logic [15:0] frame_len_t;

    // Header word layout, low bit of each field
    localparam int hdr_dst_ip_lsb = 0;
    localparam int hdr_dst_port_lsb = 32;
    localparam int hdr_src_ip_lsb = 48;
    localparam int hdr_src_port_lsb = 80;
    localparam int hdr_len_lsb = 96;
    // Bits above the length field are sent as zero

    // Framer sequence
    typedef enum logic [1:0] {
        tx_idle,
        tx_header,
        tx_payload
    } tx_state_t;

    // Parser sequence, drop covers frames for other nodes
    typedef enum logic [1:0] {
        rx_header,
        rx_payload,
        rx_drop
    } rx_state_t;

endpackage

/* hw/gbe_stream_fifo.sv */
`timescale 1ns/1ns

module gbe_stream_fifo #(
    parameter int width = 32,
    parameter int depth = 16
) (
    input  logic                          user_clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic [width-1:0]              wr_data,
    input  logic                          rd_en,
    output logic [width-1:0]              rd_data,
    output logic                          full,
    output logic                          empty,
    output logic [$clog2(depth+1)-1:0]    count
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [cnt_w-1:0] max_count = cnt_w'(depth);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic do_wr;
    logic do_rd;

    // Depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == last_slot) ? '0 : ptr + 1'b1;
    endfunction

    // Writes when full and reads when empty are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full = (count == max_count);
    assign empty = (count == '0);

    // First word falls through to the output
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge user_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge user_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/udp_rx_parser.sv */
`timescale 1ns/1ns

module udp_rx_parser #(
    parameter gbe_pkg::ip_addr_t local_ip = 32'h0A000001
) (
    input  logic               user_clk,
    input  logic               rst,
    input  gbe_pkg::gbe_word_t link_data,
    input  logic               link_valid,
    input  logic               link_last,
    input  logic               fifo_full,
    input  logic               overrun_ack,
    output logic               fifo_wr,
    output gbe_pkg::gbe_word_t fifo_data,
    output logic               fifo_last,
    output gbe_pkg::ip_addr_t  src_ip_o,
    output gbe_pkg::udp_port_t src_port_o,
    output gbe_pkg::ip_addr_t  dst_ip_o,
    output gbe_pkg::udp_port_t dst_port_o,
    output logic               bad_frame,
    output logic               overrun,
    output logic               rx_active
);

    import gbe_pkg::*;

    rx_state_t state;
    frame_len_t exp_len;
    frame_len_t word_cnt;
    frame_len_t word_num;
    ip_addr_t hdr_dst_ip;
    logic take_header;
    logic len_err;

    assign hdr_dst_ip = link_data[hdr_dst_ip_lsb +: $bits(ip_addr_t)];
    assign take_header = link_valid && (state == rx_header);

    // Position of the current payload word, counting from one
    assign word_num = word_cnt + 1'b1;
    assign len_err = link_last && (word_num != exp_len);

    always_ff @(posedge user_clk) begin
        if (rst) begin
            state <= rx_header;
            word_cnt <= '0;
            fifo_wr <= 1'b0;
            bad_frame <= 1'b0;
            rx_active <= 1'b0;
        end else begin
            fifo_wr <= 1'b0;
            bad_frame <= 1'b0;
            rx_active <= link_valid;
            if (link_valid) begin
                case (state)
                    rx_header: begin
                        word_cnt <= '0;
                        if (hdr_dst_ip == local_ip) begin
                            state <= rx_payload;
                        end else begin
                            state <= rx_drop;
                        end
                    end
                    rx_payload: begin
                        fifo_wr <= 1'b1;
                        word_cnt <= word_num;
                        bad_frame <= len_err;
                        if (link_last) begin
                            state <= rx_header;
                        end
                    end
                    rx_drop: begin
                        if (link_last) begin
                            bad_frame <= 1'b1;
                            state <= rx_header;
                        end
                    end
                    default: state <= rx_header;
                endcase
            end
        end
    end

    // Header fields stay put for the whole frame
    always_ff @(posedge user_clk) begin
        if (take_header) begin
            dst_ip_o <= hdr_dst_ip;
            dst_port_o <= link_data[hdr_dst_port_lsb +: $bits(udp_port_t)];
            src_ip_o <= link_data[hdr_src_ip_lsb +: $bits(ip_addr_t)];
            src_port_o <= link_data[hdr_src_port_lsb +: $bits(udp_port_t)];
            exp_len <= link_data[hdr_len_lsb +: $bits(frame_len_t)];
        end
        fifo_data <= link_data;
        fifo_last <= link_last;
    end

    // The rx FIFO drops this write, so flag it until acknowledged
    always_ff @(posedge user_clk) begin
        if (rst) begin
            overrun <= 1'b0;
        end else if (fifo_wr && fifo_full) begin
            overrun <= 1'b1;
        end else if (overrun_ack) begin
            overrun <= 1'b0;
        end
    end

endmodule

/* hw/udp_tx_framer.sv */
`timescale 1ns/1ns

module udp_tx_framer #(
    parameter gbe_pkg::ip_addr_t  local_ip = 32'h0A000001,
    parameter gbe_pkg::udp_port_t src_port = 16'h1234,
    parameter int                 tx_depth = 16,
    parameter int                 afull_margin = 4
) (
    input  logic                             user_clk,
    input  logic                             rst,
    input  logic                             wr_en,
    input  logic                             wr_last,
    input  logic                             fifo_full,
    input  logic [$clog2(tx_depth+1)-1:0]    fifo_count,
    input  gbe_pkg::gbe_word_t               fifo_data,
    input  logic                             fifo_last,
    input  gbe_pkg::ip_addr_t                dest_ip,
    input  gbe_pkg::udp_port_t               dest_port,
    output logic                             fifo_rd,
    output gbe_pkg::gbe_word_t               link_data,
    output logic                             link_valid,
    output logic                             link_last,
    output logic                             tx_afull,
    output logic                             tx_overflow,
    output logic                             tx_active
);

    import gbe_pkg::*;

    localparam int cnt_w = $clog2(tx_depth + 1);
    localparam int desc_w = $bits(frame_len_t) + $bits(ip_addr_t) + $bits(udp_port_t);
    localparam logic [cnt_w-1:0] afull_level = cnt_w'(tx_depth - afull_margin);

    tx_state_t state;
    frame_len_t word_cnt;
    frame_len_t frame_len;
    frame_len_t remaining;
    frame_len_t q_len;
    ip_addr_t q_ip;
    ip_addr_t cur_ip;
    udp_port_t q_port;
    udp_port_t cur_port;
    logic wr_ok;
    logic close_frame;
    logic desc_rd;
    logic desc_empty;
    logic [desc_w-1:0] desc_in;
    logic [desc_w-1:0] desc_out;

    assign wr_ok = wr_en && !fifo_full;
    // Length counts this word only if the FIFO took it
    assign frame_len = word_cnt + frame_len_t'(wr_ok);
    assign close_frame = wr_en && wr_last && (frame_len != '0);
    assign desc_in = {frame_len, dest_ip, dest_port};
    assign {q_len, q_ip, q_port} = desc_out;
    assign desc_rd = (state == tx_idle) && !desc_empty;

    always_ff @(posedge user_clk) begin
        if (rst) begin
            word_cnt <= '0;
        end else if (wr_en && wr_last) begin
            word_cnt <= '0;
        end else if (wr_ok) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // Each queued frame holds at least one word in the tx FIFO
    gbe_stream_fifo #(
        .width(desc_w),
        .depth(tx_depth)
    ) len_queue (
        .user_clk(user_clk),
        .rst(rst),
        .wr_en(close_frame),
        .wr_data(desc_in),
        .rd_en(desc_rd),
        .rd_data(desc_out),
        .full(),
        .empty(desc_empty),
        .count()
    );

    always_ff @(posedge user_clk) begin
        if (rst) begin
            state <= tx_idle;
            remaining <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    if (!desc_empty) begin
                        remaining <= q_len;
                        state <= tx_header;
                    end
                end
                tx_header: state <= tx_payload;
                tx_payload: begin
                    remaining <= remaining - 1'b1;
                    if (link_last) begin
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge user_clk) begin
        if (desc_rd) begin
            cur_ip <= q_ip;
            cur_port <= q_port;
        end
    end

    always_comb begin
        link_data = fifo_data;
        link_valid = 1'b0;
        link_last = 1'b0;
        fifo_rd = 1'b0;
        case (state)
            tx_header: begin
                link_data = '0;
                link_data[hdr_dst_ip_lsb +: $bits(ip_addr_t)] = cur_ip;
                link_data[hdr_dst_port_lsb +: $bits(udp_port_t)] = cur_port;
                link_data[hdr_src_ip_lsb +: $bits(ip_addr_t)] = local_ip;
                link_data[hdr_src_port_lsb +: $bits(udp_port_t)] = src_port;
                link_data[hdr_len_lsb +: $bits(frame_len_t)] = remaining;
                link_valid = 1'b1;
            end
            tx_payload: begin
                link_valid = 1'b1;
                fifo_rd = 1'b1;
                // Stop at whichever comes first
                link_last = fifo_last || (remaining == frame_len_t'(1));
            end
            default: ;
        endcase
    end

    assign tx_afull = (fifo_count >= afull_level);
    assign tx_active = link_valid;

    always_ff @(posedge user_clk) begin
        if (rst) begin
            tx_overflow <= 1'b0;
        end else if (wr_en && fifo_full) begin
            tx_overflow <= 1'b1;
        end
    end

endmodule

/* list.f */
hw/gbe_pkg.sv
hw/gbe_stream_fifo.sv
hw/udp_tx_framer.sv
hw/udp_rx_parser.sv
hw/gbe_activity_leds.sv
hw/casper_gbe_loopback.sv
bench/gbe_clock_gen.sv
bench/gbe_props.sv
bench/gbe_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module gbe_tb -o gbe_sim

out=$(./obj_dir/gbe_sim)
echo "$out"

# Passes only if the testbench printed its pass line
echo "$out" | grep -qx "PASS: all tests"
